/* Bender.yml */
package:
  name: gf_hash

export_include_dirs:
  - .

sources:
  - gf_pkg.sv
  - gf_mult.sv
  - gf_hash_ctrl.sv
  - gf_hash_top.sv
  - target: test
    files:
      - tb_gf_checker.sv
      - tb_gf_hash.sv

/* gf_hash_ctrl.sv */
// ************************************************
// strobes act only while idle, ignored while busy_o is high
// clear wins over data in the same cycle, no input queue
// ************************************************

`timescale 1ns/10ps

module gf_hash_ctrl (
  input  logic             clk_i,
  input  logic             rst_ni,
  // key load strobe and value
  input  logic             key_load_i,
  input  gf_pkg::gf_elem_t key_i,
  // accumulator clear strobe
  input  logic             clear_i,
  // data word strobe and value
  input  logic             data_valid_i,
  input  gf_pkg::gf_elem_t data_i,
  // multiplier side
  input  logic             mult_ack_i,
  input  gf_pkg::gf_elem_t mult_prod_i,
  output logic             mult_req_o,
  output gf_pkg::gf_elem_t mult_a_o,
  output gf_pkg::gf_elem_t mult_b_o,
  // status and result
  output logic             busy_o,
  output logic             digest_valid_o,
  output gf_pkg::gf_elem_t digest_o
);

  gf_pkg::hash_state_e state_q;
  gf_pkg::hash_state_e state_d;

  // key register, multiplier operand b
  gf_pkg::gf_elem_t key_q;

  // Horner accumulator, also the digest
  gf_pkg::gf_elem_t acc_q;

  // operand a, accumulator xor data, held for the whole product
  gf_pkg::gf_elem_t mult_a_q;

  // one cycle digest pulse
  logic digest_valid_q;

  // decoded events
  logic idle;
  logic accept;
  logic do_clear;
  logic do_key_load;
  logic done;

  assign idle        = (state_q == gf_pkg::ST_IDLE);
  // clear has priority over a data word in the same idle cycle
  assign do_clear    = idle && clear_i;
  assign accept      = idle && data_valid_i && !clear_i;
  assign do_key_load = idle && key_load_i;
  // product lands on the acknowledge edge
  assign done        = (state_q == gf_pkg::ST_MULT) && mult_ack_i;

  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      gf_pkg::ST_IDLE: begin
        if (accept) begin
          state_d = gf_pkg::ST_MULT;
        end
      end
      gf_pkg::ST_MULT: begin
        if (mult_ack_i) begin
          state_d = gf_pkg::ST_IDLE;
        end
      end
      default: begin
        state_d = gf_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= gf_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // key register
  // a key loaded with a data word already applies to that word
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q <= '0;
    end else if (do_key_load) begin
      key_q <= key_i;
    end
  end

  // accumulator
  // clear and product capture never coincide, clear needs idle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (do_clear) begin
      acc_q <= '0;
    end else if (done) begin
      acc_q <= mult_prod_i;
    end
  end

  // operand a latch, loaded on the accepting edge only
  always_ff @(posedge clk_i) begin
    if (accept) begin
      mult_a_q <= acc_q ^ data_i;
    end
  end

  // digest pulse follows the capture edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      digest_valid_q <= 1'b0;
    end else begin
      digest_valid_q <= done;
    end
  end

  // request stays up until the acknowledge edge
  assign mult_req_o = (state_q == gf_pkg::ST_MULT);
  assign mult_a_o   = mult_a_q;
  assign mult_b_o   = key_q;

  // busy for exactly the multiply cycles
  assign busy_o         = (state_q == gf_pkg::ST_MULT);
  assign digest_valid_o = digest_valid_q;
  // digest always shows the accumulator
  assign digest_o       = acc_q;

endmodule

/* gf_hash_top.sv */
// ************************************************
// digest pulse starts GF_LOOPS cycles after the accepting edge
// source must watch busy_o, strobes while busy are dropped
// ************************************************

`timescale 1ns/10ps

`include "gf_params.svh"

module gf_hash_top (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             key_load_i,
  input  gf_pkg::gf_elem_t key_i,
  input  logic             clear_i,
  input  logic             data_valid_i,
  input  gf_pkg::gf_elem_t data_i,
  output logic             busy_o,
  output logic             digest_valid_o,
  output gf_pkg::gf_elem_t digest_o
);

  // controller to multiplier
  logic             mult_req;
  gf_pkg::gf_elem_t mult_a;
  gf_pkg::gf_elem_t mult_b;

  // multiplier back to controller
  logic             mult_ack;
  gf_pkg::gf_elem_t mult_prod;

  gf_hash_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .key_load_i     (key_load_i),
    .key_i          (key_i),
    .clear_i        (clear_i),
    .data_valid_i   (data_valid_i),
    .data_i         (data_i),
    .mult_ack_i     (mult_ack),
    .mult_prod_i    (mult_prod),
    .mult_req_o     (mult_req),
    .mult_a_o       (mult_a),
    .mult_b_o       (mult_b),
    .busy_o         (busy_o),
    .digest_valid_o (digest_valid_o),
    .digest_o       (digest_o)
  );

  // digit serial multiplier, GF_STAGES key bits per cycle
  gf_mult #(
    .Width          (`GF_WIDTH),
    .StagesPerCycle (`GF_STAGES),
    .IPoly          (`GF_IPOLY)
  ) u_mult (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (mult_req),
    .operand_a_i (mult_a),
    .operand_b_i (mult_b),
    .ack_o       (mult_ack),
    .prod_o      (mult_prod)
  );

endmodule

/* gf_mult.sv */
// ************************************************
// not pipelined, one product per Width/StagesPerCycle cycles
// StagesPerCycle below Width, operands held while req_i is high
// ************************************************

`timescale 1ns/10ps

module gf_mult #(
  parameter int              Width          = 32,
  parameter int              StagesPerCycle = 8,
  // reduction polynomial, x^Width term implied
  parameter logic [Width-1:0] IPoly         = 32'h0000_008D
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             req_i,
  input  logic [Width-1:0] operand_a_i,
  input  logic [Width-1:0] operand_b_i,
  output logic             ack_o,
  output logic [Width-1:0] prod_o
);

  // number of digit cycles per product
  localparam int Loops    = Width / StagesPerCycle;
  localparam int CntWidth = $clog2(Loops);

  // operand b split into digits, digit 0 is the low slice
  logic [Loops-1:0][StagesPerCycle-1:0] b_digits;
  logic [StagesPerCycle-1:0]            b_slice;

  // rows a*x^k for the bits of the current digit
  logic [StagesPerCycle-1:0][Width-1:0] rows;

  // last row of the previous digit, next digit continues from it
  logic [Width-1:0] row_q;

  // running partial product
  logic [Width-1:0] part_q;
  logic [Width-1:0] part_d;

  // digit counter
  logic [CntWidth-1:0] cnt_q;
  logic                first_digit;
  logic                last_digit;

  // multiply by x with reduction
  function automatic logic [Width-1:0] mul_x(
    input logic [Width-1:0] value
  );
    logic [Width-1:0] shifted;
    shifted = value << 1;
    if (value[Width-1]) begin
      shifted = shifted ^ IPoly;
    end
    return shifted;
  endfunction

  // build StagesPerCycle successive powers of x times the seed
  // first digit starts at the seed itself, later digits step once more
  function automatic logic [StagesPerCycle-1:0][Width-1:0] build_rows(
    input logic [Width-1:0] seed,
    input logic             start
  );
    logic [StagesPerCycle-1:0][Width-1:0] m;
    m = '0;
    m[0] = start ? seed : mul_x(seed);
    for (int k = 1; k < StagesPerCycle; k++) begin
      m[k] = mul_x(m[k-1]);
    end
    return m;
  endfunction

  // add up the rows picked by the digit bits
  function automatic logic [Width-1:0] sum_rows(
    input logic [StagesPerCycle-1:0][Width-1:0] m,
    input logic [StagesPerCycle-1:0]            sel
  );
    logic [Width-1:0] acc;
    acc = '0;
    for (int k = 0; k < StagesPerCycle; k++) begin
      if (sel[k]) begin
        acc = acc ^ m[k];
      end
    end
    return acc;
  endfunction

  assign b_digits    = operand_b_i;
  assign b_slice     = b_digits[cnt_q];
  assign first_digit = (cnt_q == '0);
  assign last_digit  = (cnt_q == CntWidth'(Loops - 1));

  // row matrix, seeded from operand a only in the first digit
  assign rows   = first_digit ? build_rows(operand_a_i, 1'b1) : build_rows(row_q, 1'b0);
  assign part_d = part_q ^ sum_rows(rows, b_slice);

  // product complete during the last digit
  assign ack_o = last_digit;

  // output held at operand a until the product is ready
  assign prod_o = ack_o ? part_d : operand_a_i;

  // digit counter
  // wraps to zero on the handshake edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (req_i && ack_o) begin
      cnt_q <= '0;
    end else if (req_i) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // partial product and saved row
  // both cleared after the last digit for the next request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      part_q <= '0;
      row_q  <= '0;
    end else if (ack_o) begin
      part_q <= '0;
      row_q  <= '0;
    end else if (req_i) begin
      part_q <= part_d;
      row_q  <= rows[StagesPerCycle-1];
    end
  end

endmodule

/* gf_params.svh */
// ************************************************
// GF_STAGES must be a power of two, divide GF_WIDTH and stay below it
// GF_IPOLY drops the x^GF_WIDTH term and must be irreducible
// ************************************************

`ifndef GF_PARAMS_SVH
`define GF_PARAMS_SVH

// field degree, also the bit width of one field element
`define GF_WIDTH 32

// operand b bits consumed per multiplier cycle
// power of two, divides GF_WIDTH, smaller than GF_WIDTH
`define GF_STAGES 8

// cycles per product
`define GF_LOOPS (`GF_WIDTH / `GF_STAGES)

// reduction polynomial without its top term
// bits 7, 3, 2 and 0 give x^32 + x^7 + x^3 + x^2 + 1
`define GF_IPOLY 32'h0000_008D

`endif

/* gf_pkg.sv */
// ************************************************
// field width comes from gf_params.svh
// ************************************************

`include "gf_params.svh"

package gf_pkg;

  // one element of GF(2^GF_WIDTH)
  // bit i holds the coefficient of x^i, no bit reflection
  typedef logic [`GF_WIDTH-1:0] gf_elem_t;

  // hash controller states
  // idle accepts strobes, mult waits on the multiplier
  typedef enum logic [0:0] {
    ST_IDLE = 1'b0,
    ST_MULT = 1'b1
  } hash_state_e;

endpackage

/* src.f */
+incdir+.
gf_pkg.sv
gf_mult.sv
gf_hash_ctrl.sv
gf_hash_top.sv
tb_gf_checker.sv
tb_gf_hash.sv

/* tb_gf_checker.sv */
// ************************************************
// model follows strobes only while its own busy is low
// samples everything on the rising edge
// ************************************************

`timescale 1ns/10ps

`include "gf_params.svh"

module tb_gf_checker (
  input logic             clk_i,
  input logic             rst_ni,
  input logic             key_load_i,
  input gf_pkg::gf_elem_t key_i,
  input logic             clear_i,
  input logic             data_valid_i,
  input gf_pkg::gf_elem_t data_i,
  input logic             busy_i,
  input logic             digest_valid_i,
  input gf_pkg::gf_elem_t digest_i
);

  int    check_count = 0;
  int    error_count = 0;
  string test_name   = "none";

  // reference key, accumulator and pending product
  gf_pkg::gf_elem_t    key_m;
  gf_pkg::gf_elem_t    acc_m;
  gf_pkg::gf_elem_t    expected_m;
  gf_pkg::hash_state_e state_m;
  int                  cycle_m;
  int                  accept_cycle_m;
  logic                reset_seen;
  // expected busy level before this edge
  logic                busy_m;

  task automatic start_test(input string name);
    test_name = name;
  endtask

  // plain shift and add, reduced bit by bit
  function automatic gf_pkg::gf_elem_t gf_mul_ref(
    input gf_pkg::gf_elem_t a,
    input gf_pkg::gf_elem_t b
  );
    gf_pkg::gf_elem_t res;
    gf_pkg::gf_elem_t sh;
    res = '0;
    sh  = a;
    for (int i = 0; i < `GF_WIDTH; i++) begin
      if (b[i]) begin
        res = res ^ sh;
      end
      // sh becomes a * x^(i+1)
      if (sh[`GF_WIDTH-1]) begin
        sh = (sh << 1) ^ `GF_IPOLY;
      end else begin
        sh = sh << 1;
      end
    end
    return res;
  endfunction

  task automatic check_digest(input gf_pkg::gf_elem_t exp_v, input gf_pkg::gf_elem_t act_v);
    check_count++;
    if (exp_v !== act_v) begin
      error_count++;
      $display("[ERROR] test %s, digest: expected %h, actual %h, model state %s",
               test_name, exp_v, act_v, state_m.name());
    end
  endtask

  task automatic check_latency(input int exp_v, input int act_v);
    check_count++;
    if (exp_v != act_v) begin
      error_count++;
      $display("[ERROR] test %s, latency: expected %0d, actual %0d",
               test_name, exp_v, act_v);
    end
  endtask

  task automatic check_busy(input logic exp_v, input logic act_v);
    check_count++;
    if (exp_v !== act_v) begin
      error_count++;
      $display("[ERROR] test %s, busy: expected %0b, actual %0b",
               test_name, exp_v, act_v);
    end
  endtask

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      key_m          = '0;
      acc_m          = '0;
      expected_m     = '0;
      state_m        = gf_pkg::ST_IDLE;
      cycle_m        = 0;
      accept_cycle_m = 0;
      reset_seen     = 1'b0;
      busy_m         = 1'b0;
    end else begin
      cycle_m++;
      // first edge out of reset
      if (!reset_seen) begin
        reset_seen = 1'b1;
        check_count++;
        if (busy_i || digest_valid_i) begin
          error_count++;
          $display("busy_o or digest_valid_o is high right after reset");
        end
        check_digest('0, digest_i);
      end
      // busy over the GF_LOOPS edges that follow the accepting edge
      busy_m = (state_m == gf_pkg::ST_MULT) &&
               (cycle_m - accept_cycle_m <= `GF_LOOPS);
      check_busy(busy_m, busy_i);
      // pulse seen here rose on the previous edge
      if (digest_valid_i) begin
        if (state_m != gf_pkg::ST_MULT) begin
          error_count++;
          $display("digest pulse in test %s with no data word pending", test_name);
        end else begin
          check_digest(expected_m, digest_i);
          check_latency(`GF_LOOPS, cycle_m - 1 - accept_cycle_m);
          acc_m   = expected_m;
          state_m = gf_pkg::ST_IDLE;
        end
      end
      // strobes count only while idle
      if (!busy_m) begin
        // a key loaded with a data word applies to that word
        if (key_load_i) begin
          key_m = key_i;
        end
        if (clear_i) begin
          acc_m = '0;
        end else if (data_valid_i) begin
          expected_m     = gf_mul_ref(acc_m ^ data_i, key_m);
          state_m        = gf_pkg::ST_MULT;
          accept_cycle_m = cycle_m;
        end
      end
    end
  end

endmodule

/* tb_gf_hash.sv */
// ************************************************
// strobes driven on the falling edge, LFSR seed 11
// every wait gives up after TimeoutCycles cycles
// ************************************************

`timescale 1ns/10ps

`include "gf_params.svh"

module tb_gf_hash;

  // generous bound on any single wait
  localparam int TimeoutCycles = 16 * `GF_LOOPS;

  logic             clk_i;
  logic             rst_ni;
  logic             key_load;
  gf_pkg::gf_elem_t key;
  logic             clear;
  logic             data_valid;
  gf_pkg::gf_elem_t data;
  logic             busy;
  logic             digest_valid;
  gf_pkg::gf_elem_t digest;

  // Galois LFSR state, x^32 + x^22 + x^2 + x + 1
  logic [31:0] lfsr_q;
  int          timeouts;
  string       test_name;

  gf_hash_top UUT (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .key_load_i     (key_load),
    .key_i          (key),
    .clear_i        (clear),
    .data_valid_i   (data_valid),
    .data_i         (data),
    .busy_o         (busy),
    .digest_valid_o (digest_valid),
    .digest_o       (digest)
  );

  // watches the same ports and does all comparing
  tb_gf_checker u_checker (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .key_load_i     (key_load),
    .key_i          (key),
    .clear_i        (clear),
    .data_valid_i   (data_valid),
    .data_i         (data),
    .busy_i         (busy),
    .digest_valid_i (digest_valid),
    .digest_i       (digest)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // one LFSR step per bit taken
  function automatic logic lfsr_bit();
    logic out_bit;
    out_bit = lfsr_q[0];
    lfsr_q  = lfsr_q >> 1;
    if (out_bit) begin
      lfsr_q = lfsr_q ^ 32'h8020_0003;
    end
    return out_bit;
  endfunction

  function automatic gf_pkg::gf_elem_t next_word();
    gf_pkg::gf_elem_t w;
    w = '0;
    for (int i = 0; i < `GF_WIDTH; i++) begin
      w = {w[`GF_WIDTH-2:0], lfsr_bit()};
    end
    return w;
  endfunction

  // closing line with the counts, then the verdict
  task automatic finish_run();
    $display("checks: %0d, errors: %0d, timeouts: %0d",
             u_checker.check_count, u_checker.error_count, timeouts);
    if (u_checker.error_count == 0 && timeouts == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    u_checker.start_test(name);
    $display("running test %s", name);
  endtask

  // returns on a falling edge with busy_o low
  task automatic wait_idle();
    int cnt;
    cnt = 0;
    while (busy && cnt < TimeoutCycles) begin
      @(negedge clk_i);
      cnt++;
    end
    if (busy) begin
      $display("timeout in test %s: busy_o never went low", test_name);
      timeouts++;
      finish_run();
    end
  endtask

  // returns on the falling edge inside the digest pulse
  task automatic wait_digest();
    int   cnt;
    logic seen;
    cnt  = 0;
    seen = digest_valid;
    while (!seen && cnt < TimeoutCycles) begin
      @(negedge clk_i);
      seen = digest_valid;
      cnt++;
    end
    if (!seen) begin
      $display("timeout in test %s: no digest pulse after a data word", test_name);
      timeouts++;
      finish_run();
    end
  endtask

  // strobes high for exactly one rising edge
  task automatic pulse_inputs(
    input logic             kl,
    input gf_pkg::gf_elem_t k,
    input logic             cl,
    input logic             dv,
    input gf_pkg::gf_elem_t d
  );
    @(negedge clk_i);
    key_load   = kl;
    key        = k;
    clear      = cl;
    data_valid = dv;
    data       = d;
    @(negedge clk_i);
    key_load   = 1'b0;
    clear      = 1'b0;
    data_valid = 1'b0;
  endtask

  task automatic load_key(input gf_pkg::gf_elem_t k);
    wait_idle();
    pulse_inputs(1'b1, k, 1'b0, 1'b0, '0);
  endtask

  task automatic clear_acc();
    wait_idle();
    pulse_inputs(1'b0, '0, 1'b1, 1'b0, '0);
  endtask

  task automatic send_word(input gf_pkg::gf_elem_t d);
    wait_idle();
    pulse_inputs(1'b0, '0, 1'b0, 1'b1, d);
    wait_digest();
  endtask

  // data word followed by strobes on every input while busy
  task automatic send_word_with_noise(input gf_pkg::gf_elem_t d);
    wait_idle();
    pulse_inputs(1'b0, '0, 1'b0, 1'b1, d);
    // noise on every busy edge, the capture edge included
    for (int k = 0; k < `GF_LOOPS; k++) begin
      key_load   = 1'b1;
      key        = next_word();
      clear      = 1'b1;
      data_valid = 1'b1;
      data       = next_word();
      @(negedge clk_i);
    end
    key_load   = 1'b0;
    clear      = 1'b0;
    data_valid = 1'b0;
    wait_digest();
  endtask

  initial begin
    lfsr_q     = 32'd11;
    timeouts   = 0;
    rst_ni     = 1'b0;
    key_load   = 1'b0;
    key        = '0;
    clear      = 1'b0;
    data_valid = 1'b0;
    data       = '0;
    begin_test("reset");
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    repeat (2) @(negedge clk_i);

    begin_test("single_product");
    load_key(next_word());
    clear_acc();
    send_word(next_word());
    // unit key passes the word through
    begin_test("key_one");
    load_key(32'h1);
    clear_acc();
    send_word(next_word());
    begin_test("key_zero");
    load_key('0);
    clear_acc();
    send_word(next_word());

    begin_test("horner_chain");
    load_key(next_word());
    clear_acc();
    for (int i = 0; i < 8; i++) begin
      send_word(next_word());
    end

    begin_test("clear_restart");
    send_word(next_word());
    clear_acc();
    send_word(next_word());

    // clear together with data, data must be dropped
    begin_test("clear_wins");
    wait_idle();
    pulse_inputs(1'b0, '0, 1'b1, 1'b1, next_word());
    send_word(next_word());

    begin_test("busy_ignored");
    for (int i = 0; i < 3; i++) begin
      send_word_with_noise(next_word());
    end

    repeat (2) @(negedge clk_i);
    finish_run();
  end

endmodule
